// ==== design/uart_pkg.sv ====
//------------------------------
// Shared types for the UART packet receiver
//   byte, bit count and length vectors
//   start-of-frame marker
//   receiver and decoder state encodings
//------------------------------

package uart_pkg;

  // Serial data, FIFO words, payload and checksum
  typedef logic [7:0] byte_t;

  // Ticks seen inside one serial frame (start, 8 data, stop)
  typedef logic [3:0] bit_cnt_t;

  // Packet length byte and payload down-counter
  typedef logic [7:0] len_t;

  // Every frame opens with this byte
  localparam byte_t SOF_BYTE = 8'h7E;

  // Serial receiver sequence
  typedef enum logic [1:0] {
    IDLE,
    RECV,
    LOAD,
    DAV
  } rx_state_t;

  // Frame parser position
  typedef enum logic [1:0] {
    HUNT,
    LEN,
    PAYLOAD,
    CSUM
  } dec_state_t;

endpackage

// ==== design/baud_tick_gen.sv ====
//------------------------------
// Bit-period tick generator
//   first tick half a period after enable
//   then one tick per bit period
//------------------------------

module baud_tick_gen #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic clk,
  input  logic rstn,
  input  logic enable,
  output logic tick
);

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] HALF_LOAD = CW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CW-1:0] FULL_LOAD = CW'(CLKS_PER_BIT - 1);

  logic [CW-1:0] cnt;

  // Down-counter, parked at half a period while disabled
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt <= HALF_LOAD;
    end else if (!enable) begin
      cnt <= HALF_LOAD;
    end else if (cnt == '0) begin
      // Reload so the next sample is one full bit later
      cnt <= FULL_LOAD;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // Pulse lands in the middle of each bit
  assign tick = enable && (cnt == '0);

endmodule

// ==== design/uart_rx.sv ====
//------------------------------
// Asynchronous serial receiver
//   two-flop input synchronizer
//   start edge detect, 10-bit shift register
//   stop bit check, byte strobe or frame error
//------------------------------

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            rx,
  output logic            byte_strobe,
  output uart_pkg::byte_t byte_data,
  output logic            frame_err
);

  import uart_pkg::*;

  // Synchronizer and edge detect
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;

  // Bit timing
  logic     baud_en;
  logic     tick;
  bit_cnt_t bit_cnt;

  // Frame capture
  logic [9:0] shift_q;
  logic       stop_ok;
  rx_state_t  state;

  //------------------------------
  // Datapath
  //------------------------------

  // Line idles high, so reset the flops to 1
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Sampling clock only runs while a frame is being received
  assign baud_en = (state == RECV);

  baud_tick_gen #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) baud_tick_gen_i (
    .clk   (clk),
    .rstn  (rstn),
    .enable(baud_en),
    .tick  (tick)
  );

  // LSB first, so new bits enter at the top
  // After 10 samples: [0] start, [8:1] data, [9] stop
  always_ff @(posedge clk) begin
    if (tick) begin
      shift_q <= {rx_sync, shift_q[9:1]};
    end
  end

  // Output byte and stop flag latched once per frame
  always_ff @(posedge clk) begin
    if (state == LOAD) begin
      byte_data <= shift_q[8:1];
      stop_ok   <= shift_q[9];
    end
  end

  //------------------------------
  // Control FSM
  //------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          bit_cnt <= '0;
          // Falling edge only, a held-low line does not restart
          if (rx_prev && !rx_sync) begin
            state <= RECV;
          end
        end
        RECV: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            // Tenth sample is mid stop bit
            if (bit_cnt == 4'd9) begin
              state <= LOAD;
            end
          end
        end
        LOAD:    state <= DAV;
        DAV:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // One of the two fires in DAV, never both
  assign byte_strobe = (state == DAV) && stop_ok;
  assign frame_err   = (state == DAV) && !stop_ok;

  // A captured frame always holds exactly ten samples
  a_ten_samples: assert property (@(posedge clk) disable iff (!rstn)
    (state == LOAD) |-> (bit_cnt == 4'd10))
    else $error("uart_rx: frame captured without ten samples");

endmodule

// ==== design/byte_fifo.sv ====
//------------------------------
// Byte FIFO
//   circular buffer, first-word fall-through
//   drops writes when full with an overflow pulse
//------------------------------

module byte_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            wr_en,
  input  uart_pkg::byte_t wr_data,
  input  logic            rd_en,
  output uart_pkg::byte_t rd_data,
  output logic            empty,
  output logic            overflow
);

  import uart_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam logic [AW:0] DEPTH_CNT = (AW + 1)'(FIFO_DEPTH);

  byte_t         mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full  = (count == DEPTH_CNT);
  assign empty = (count == '0);

  // Full is judged before any same-cycle read
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= wr_en && full;
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word is always presented
  assign rd_data = mem[rd_ptr];

  a_no_read_empty: assert property (@(posedge clk) disable iff (!rstn)
    rd_en |-> !empty)
    else $error("byte_fifo: read while empty");

  // Occupancy always matches the distance between the pointers
  a_count_ptrs: assert property (@(posedge clk) disable iff (!rstn)
    count[AW-1:0] == AW'(wr_ptr - rd_ptr))
    else $error("byte_fifo: occupancy and pointers disagree");

endmodule

// ==== design/packet_decoder.sv ====
//------------------------------
// Packet decoder
//   SOF, length, payload, XOR checksum
//   payload strobes and a done pulse with status
//------------------------------

module packet_decoder #(
  parameter int MAX_LEN = 16
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            hold,
  input  logic            empty,
  input  uart_pkg::byte_t rd_data,
  output logic            rd_en,
  output logic            pay_valid,
  output uart_pkg::byte_t pay_data,
  output logic            pkt_done,
  output logic            pkt_ok,
  output uart_pkg::len_t  pkt_len
);

  import uart_pkg::*;

  localparam len_t LEN_MAX = len_t'(MAX_LEN);

  dec_state_t state;
  len_t       len_q;
  len_t       remaining;
  byte_t      csum;
  logic       len_legal;

  // Pop whenever a byte waits and nobody holds us off
  assign rd_en = !empty && !hold;

  // Zero and oversize lengths are dropped silently
  assign len_legal = (rd_data != '0) && (rd_data <= LEN_MAX);

  //------------------------------
  // Frame FSM
  //------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= HUNT;
      pay_valid <= 1'b0;
      pkt_done  <= 1'b0;
    end else begin
      pay_valid <= 1'b0;
      pkt_done  <= 1'b0;
      if (rd_en) begin
        case (state)
          // Skip anything until a start marker
          HUNT: begin
            if (rd_data == SOF_BYTE) begin
              state <= LEN;
            end
          end
          LEN: begin
            state <= len_legal ? PAYLOAD : HUNT;
          end
          PAYLOAD: begin
            pay_valid <= 1'b1;
            if (remaining == 8'd1) begin
              state <= CSUM;
            end
          end
          CSUM: begin
            pkt_done <= 1'b1;
            state    <= HUNT;
          end
          default: state <= HUNT;
        endcase
      end
    end
  end

  //------------------------------
  // Payload and checksum path
  //------------------------------

  always_ff @(posedge clk) begin
    if (rd_en) begin
      case (state)
        LEN: begin
          // Checksum starts from the length byte
          len_q     <= rd_data;
          remaining <= rd_data;
          csum      <= rd_data;
        end
        PAYLOAD: begin
          pay_data  <= rd_data;
          csum      <= csum ^ rd_data;
          remaining <= remaining - 1'b1;
        end
        CSUM: begin
          pkt_ok  <= (rd_data == csum);
          pkt_len <= len_q;
        end
        default: begin
          csum <= csum;
        end
      endcase
    end
  end

  // Bytes left to forward stay within the accepted length range
  a_remaining_range: assert property (@(posedge clk) disable iff (!rstn)
    (state == PAYLOAD) |-> (remaining != '0 && remaining <= LEN_MAX))
    else $error("packet_decoder: payload count out of range");

endmodule

// ==== design/uart_packet_rx.sv ====
//------------------------------
// UART packet receiver top level
//   serial receiver, byte FIFO, frame decoder
//------------------------------

module uart_packet_rx #(
  parameter int CLKS_PER_BIT = 16,
  parameter int FIFO_DEPTH   = 8,
  parameter int MAX_LEN      = 16
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            rx,
  input  logic            hold,
  output logic            pay_valid,
  output uart_pkg::byte_t pay_data,
  output logic            pkt_done,
  output logic            pkt_ok,
  output uart_pkg::len_t  pkt_len,
  output logic            frame_err,
  output logic            overflow
);

  import uart_pkg::*;

  // Receiver to FIFO
  logic  rx_strobe;
  byte_t rx_byte;

  // FIFO to decoder
  logic  fifo_empty;
  logic  fifo_rd_en;
  byte_t fifo_rd_data;

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_rx_i (
    .clk        (clk),
    .rstn       (rstn),
    .rx         (rx),
    .byte_strobe(rx_strobe),
    .byte_data  (rx_byte),
    .frame_err  (frame_err)
  );

  byte_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) byte_fifo_i (
    .clk     (clk),
    .rstn    (rstn),
    .wr_en   (rx_strobe),
    .wr_data (rx_byte),
    .rd_en   (fifo_rd_en),
    .rd_data (fifo_rd_data),
    .empty   (fifo_empty),
    .overflow(overflow)
  );

  packet_decoder #(
    .MAX_LEN(MAX_LEN)
  ) packet_decoder_i (
    .clk      (clk),
    .rstn     (rstn),
    .hold     (hold),
    .empty    (fifo_empty),
    .rd_data  (fifo_rd_data),
    .rd_en    (fifo_rd_en),
    .pay_valid(pay_valid),
    .pay_data (pay_data),
    .pkt_done (pkt_done),
    .pkt_ok   (pkt_ok),
    .pkt_len  (pkt_len)
  );

endmodule

// ==== tests/tb_uart_packet_rx.sv ====
//------------------------------
// Testbench for the UART packet receiver
//   serial bit driver, packet builder
//   reference checksum, result queues, monitor
//   watchdog
//------------------------------

module tb_uart_packet_rx;

  import uart_pkg::*;

  localparam int CLKS_PER_BIT = 16;
  localparam int FIFO_DEPTH   = 8;
  localparam int MAX_LEN      = 16;
  localparam int NUM_GOOD     = 6;
  localparam int NUM_BAD      = 3;
  // Upper bound on bytes sent, idle gaps counted as extra bits
  localparam int MAX_BYTES = (NUM_GOOD + NUM_BAD + 2) * (MAX_LEN + 3) + FIFO_DEPTH + 16;
  localparam int MAX_BITS  = MAX_BYTES * 10 + 128;
  localparam int WATCHDOG_TIME = MAX_BITS * CLKS_PER_BIT * 8 * 3 / 2 + 20000;

  logic  clk;
  logic  rstn;
  logic  rx;
  logic  hold;
  logic  pay_valid;
  byte_t pay_data;
  logic  pkt_done;
  logic  pkt_ok;
  len_t  pkt_len;
  logic  frame_err;
  logic  overflow;

  // Expected results, pushed when a packet is built
  byte_t exp_pay[$];
  bit    exp_ok[$];
  len_t  exp_len[$];
  byte_t pkt_pay[$];

  int exp_frame_err = 0;
  int obs_frame_err = 0;
  int exp_overflow  = 0;
  int obs_overflow  = 0;
  int value_errs    = 0;
  int event_errs    = 0;

  uart_packet_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .MAX_LEN     (MAX_LEN)
  ) uart_packet_rx_i (
    .clk      (clk),
    .rstn     (rstn),
    .rx       (rx),
    .hold     (hold),
    .pay_valid(pay_valid),
    .pay_data (pay_data),
    .pkt_done (pkt_done),
    .pkt_ok   (pkt_ok),
    .pkt_len  (pkt_len),
    .frame_err(frame_err),
    .overflow (overflow)
  );

  always #4 clk = ~clk;

  //------------------------------
  // Stimulus helpers
  //------------------------------

  // XOR of the length byte and every payload byte
  function automatic byte_t packet_checksum(input byte_t pay[$]);
    byte_t sum;
    sum = byte_t'(pay.size());
    foreach (pay[i]) begin
      sum = sum ^ pay[i];
    end
    return sum;
  endfunction

  // Start bit, 8 data bits LSB first, stop bit
  task automatic send_byte(input byte_t data, input bit bad_stop);
    logic [9:0] frame;
    frame = {~bad_stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
    end
  endtask

  // Line back to idle for whole bit periods
  task automatic idle_bits(input int n);
    @(negedge clk);
    rx = 1'b1;
    repeat (n * CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic build_payload(input int n);
    pkt_pay.delete();
    repeat (n) pkt_pay.push_back(byte_t'($urandom));
  endtask

  // SOF, length, payload, checksum
  task automatic send_packet(input bit bad_csum);
    byte_t csum;
    csum = packet_checksum(pkt_pay);
    // Flipping every bit always breaks the match
    if (bad_csum) begin
      csum = ~csum;
    end
    foreach (pkt_pay[i]) begin
      exp_pay.push_back(pkt_pay[i]);
    end
    exp_ok.push_back(!bad_csum);
    exp_len.push_back(len_t'(pkt_pay.size()));
    send_byte(SOF_BYTE, 1'b0);
    send_byte(len_t'(pkt_pay.size()), 1'b0);
    foreach (pkt_pay[i]) begin
      send_byte(pkt_pay[i], 1'b0);
    end
    send_byte(csum, 1'b0);
  endtask

  // Decoder gets a few bit periods to empty the queues
  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_pay.size() != 0 || exp_ok.size() != 0) && n < 4 * CLKS_PER_BIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_pay.size() != 0 || exp_ok.size() != 0) begin
      $display("Time %0t: %0d payload bytes and %0d packet results never arrived",
               $time, exp_pay.size(), exp_ok.size());
      event_errs++;
      exp_pay.delete();
      exp_ok.delete();
      exp_len.delete();
    end
  endtask

  //------------------------------
  // Monitor
  //------------------------------

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rstn) begin
      if (pay_valid && exp_pay.size() == 0) begin
        $display("Time %0t: payload byte %02h with none expected", $time, pay_data);
        event_errs++;
      end else if (pay_valid) begin
        if (pay_data != exp_pay[0]) begin
          $display("ERR t=%0t pay_data exp=%02h got=%02h", $time, exp_pay[0], pay_data);
          value_errs++;
        end
        exp_pay.delete(0);
      end
      if (pkt_done && exp_ok.size() == 0) begin
        $display("Time %0t: packet done pulse with no packet expected", $time);
        event_errs++;
      end else if (pkt_done) begin
        if (pkt_ok != exp_ok[0]) begin
          $display("ERR t=%0t pkt_ok exp=%0b got=%0b", $time, exp_ok[0], pkt_ok);
          value_errs++;
        end
        if (pkt_len != exp_len[0]) begin
          $display("ERR t=%0t pkt_len exp=%0d got=%0d", $time, exp_len[0], pkt_len);
          value_errs++;
        end
        exp_ok.delete(0);
        exp_len.delete(0);
      end
      if (frame_err) begin
        obs_frame_err++;
      end
      if (overflow) begin
        obs_overflow++;
      end
    end
  end

  //------------------------------
  // Test sequence
  //------------------------------

  initial begin
    byte_t junk;
    clk  = 1'b0;
    rstn = 1'b0;
    rx   = 1'b1;
    hold = 1'b0;
    void'($urandom(32'h95a4_f799));
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    idle_bits(2);

    // Good packets back to back
    repeat (NUM_GOOD) begin
      build_payload($urandom_range(MAX_LEN, 1));
      send_packet(1'b0);
    end
    wait_drain();

    // Bad checksums, payload still forwarded
    repeat (NUM_BAD) begin
      build_payload($urandom_range(MAX_LEN, 1));
      send_packet(1'b1);
    end
    wait_drain();

    // Line noise, then SOF with zero and oversize lengths
    repeat (4) begin
      do begin
        junk = byte_t'($urandom);
      end while (junk == SOF_BYTE);
      send_byte(junk, 1'b0);
    end
    send_byte(SOF_BYTE, 1'b0);
    send_byte(8'h00, 1'b0);
    send_byte(SOF_BYTE, 1'b0);
    send_byte(byte_t'(MAX_LEN + 1), 1'b0);
    build_payload($urandom_range(MAX_LEN, 1));
    send_packet(1'b0);
    wait_drain();

    // Low stop bit in the idle gap
    idle_bits(2);
    send_byte(byte_t'($urandom), 1'b1);
    exp_frame_err++;
    idle_bits(2);
    build_payload($urandom_range(MAX_LEN, 1));
    send_packet(1'b0);
    wait_drain();

    // Held decoder, one packet fills the FIFO, 3 bytes overrun
    @(negedge clk);
    hold = 1'b1;
    build_payload(FIFO_DEPTH - 3);
    send_packet(1'b0);
    repeat (3) send_byte(byte_t'($urandom), 1'b0);
    exp_overflow += 3;
    idle_bits(2);
    hold = 1'b0;
    wait_drain();

    idle_bits(4);
    if (obs_frame_err != exp_frame_err) begin
      $display("ERR t=%0t frame_err pulses exp=%0d got=%0d", $time, exp_frame_err, obs_frame_err);
      value_errs++;
    end
    if (obs_overflow != exp_overflow) begin
      $display("ERR t=%0t overflow pulses exp=%0d got=%0d", $time, exp_overflow, obs_overflow);
      value_errs++;
    end
    $display("Errors: %0d wrong values, %0d missing or unexpected events",
             value_errs, event_errs);
    if (value_errs == 0 && event_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Run must finish well inside 1.5x the serial traffic time
  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired after %0d time units, the run did not complete", WATCHDOG_TIME);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
design/uart_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/byte_fifo.sv
design/packet_decoder.sv
design/uart_packet_rx.sv
tests/tb_uart_packet_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART packet receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f \
  --top-module tb_uart_packet_rx -o tb_uart_packet_rx
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_uart_packet_rx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
